//--- source/rv_core_pkg.sv
package rv_core_pkg;

    localparam int XLEN = 64;
    localparam int ILEN = 32;
    localparam int REG_ADDR_W = 5;
    localparam int MULDIV_STEPS = 64;
    localparam int MULDIV_CNT_W = $clog2(MULDIV_STEPS);

    // Major opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_LOAD = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_DIVU = 3'b101;
    localparam logic [2:0] F3_REMU = 3'b111;
    localparam logic [2:0] MEMOP_D = 3'd3;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    localparam logic [31:0] ECALL_WORD = 32'h0000_0073;

    typedef enum logic [2:0] {
        CLS_ALU, CLS_LOAD, CLS_STORE, CLS_BRANCH,
        CLS_JAL, CLS_MULDIV, CLS_ECALL, CLS_ILLEGAL
    } instr_class_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_EQ, ALU_NE
    } alu_op_e;

    typedef enum logic [1:0] {MD_MUL, MD_DIVU, MD_REMU} muldiv_op_e;

    typedef enum logic [2:0] {
        ST_FETCH, ST_EXEC, ST_MEM, ST_MULDIV, ST_RETIRE, ST_HALT
    } ctrl_state_e;

endpackage

//--- source/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] rs1,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] rs2,
    output logic [rv_core_pkg::XLEN-1:0]       rs1_data,
    output logic [rv_core_pkg::XLEN-1:0]       rs2_data,
    input  logic                                wen,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] rd,
    input  logic [rv_core_pkg::XLEN-1:0]       wdata
);

    logic [rv_core_pkg::XLEN-1:0] regs [32];

    // x0 is never written, so it reads as zero
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    a_x0_zero: assert property (@(posedge clk) disable iff (!rst)
        (rs1 == '0) |-> (rs1_data == '0));

endmodule

//--- source/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
    input  logic [rv_core_pkg::ILEN-1:0]       instr,
    output rv_core_pkg::instr_class_e           instr_class,
    output rv_core_pkg::alu_op_e                alu_op,
    output rv_core_pkg::muldiv_op_e             muldiv_op,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rs1,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rs2,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rd,
    output logic [rv_core_pkg::XLEN-1:0]       imm,
    output logic                                use_imm,
    output logic                                reg_write
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd = instr[11:7];

    always_comb begin
        instr_class = rv_core_pkg::CLS_ILLEGAL;
        alu_op = rv_core_pkg::ALU_ADD;
        muldiv_op = rv_core_pkg::MD_MUL;
        imm = {{52{instr[31]}}, instr[31:20]};
        use_imm = 1'b0;
        case (opcode)
            rv_core_pkg::OPC_OP_IMM: begin
                if (funct3 == rv_core_pkg::F3_ADD) begin
                    instr_class = rv_core_pkg::CLS_ALU;
                    use_imm = 1'b1;
                end
            end
            rv_core_pkg::OPC_OP: begin
                instr_class = rv_core_pkg::CLS_ALU;
                case ({funct7, funct3})
                    {rv_core_pkg::F7_BASE, rv_core_pkg::F3_ADD}: alu_op = rv_core_pkg::ALU_ADD;
                    {rv_core_pkg::F7_SUB, rv_core_pkg::F3_ADD}: alu_op = rv_core_pkg::ALU_SUB;
                    {rv_core_pkg::F7_BASE, rv_core_pkg::F3_AND}: alu_op = rv_core_pkg::ALU_AND;
                    {rv_core_pkg::F7_BASE, rv_core_pkg::F3_OR}: alu_op = rv_core_pkg::ALU_OR;
                    {rv_core_pkg::F7_BASE, rv_core_pkg::F3_XOR}: alu_op = rv_core_pkg::ALU_XOR;
                    {rv_core_pkg::F7_BASE, rv_core_pkg::F3_SLT}: alu_op = rv_core_pkg::ALU_SLT;
                    {rv_core_pkg::F7_MULDIV, rv_core_pkg::F3_ADD}: begin
                        instr_class = rv_core_pkg::CLS_MULDIV;
                    end
                    {rv_core_pkg::F7_MULDIV, rv_core_pkg::F3_DIVU}: begin
                        instr_class = rv_core_pkg::CLS_MULDIV;
                        muldiv_op = rv_core_pkg::MD_DIVU;
                    end
                    {rv_core_pkg::F7_MULDIV, rv_core_pkg::F3_REMU}: begin
                        instr_class = rv_core_pkg::CLS_MULDIV;
                        muldiv_op = rv_core_pkg::MD_REMU;
                    end
                    default: instr_class = rv_core_pkg::CLS_ILLEGAL;
                endcase
            end
            rv_core_pkg::OPC_LOAD: begin
                if (funct3 == rv_core_pkg::MEMOP_D) begin
                    instr_class = rv_core_pkg::CLS_LOAD;
                    use_imm = 1'b1;
                end
            end
            rv_core_pkg::OPC_STORE: begin
                if (funct3 == rv_core_pkg::MEMOP_D) begin
                    instr_class = rv_core_pkg::CLS_STORE;
                    use_imm = 1'b1;
                end
                imm = {{52{instr[31]}}, instr[31:25], instr[11:7]};
            end
            rv_core_pkg::OPC_BRANCH: begin
                if (funct3 == rv_core_pkg::F3_BEQ || funct3 == rv_core_pkg::F3_BNE) begin
                    instr_class = rv_core_pkg::CLS_BRANCH;
                end
                alu_op = (funct3 == rv_core_pkg::F3_BNE) ? rv_core_pkg::ALU_NE
                                                         : rv_core_pkg::ALU_EQ;
                imm = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            rv_core_pkg::OPC_JAL: begin
                instr_class = rv_core_pkg::CLS_JAL;
                imm = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            rv_core_pkg::OPC_SYSTEM: begin
                if (instr == rv_core_pkg::ECALL_WORD) begin
                    instr_class = rv_core_pkg::CLS_ECALL;
                end
            end
            default: instr_class = rv_core_pkg::CLS_ILLEGAL;
        endcase
    end

    assign reg_write = (instr_class == rv_core_pkg::CLS_ALU) ||
                       (instr_class == rv_core_pkg::CLS_LOAD) ||
                       (instr_class == rv_core_pkg::CLS_JAL) ||
                       (instr_class == rv_core_pkg::CLS_MULDIV);

endmodule

//--- source/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
    input  rv_core_pkg::alu_op_e          alu_op,
    input  logic [rv_core_pkg::XLEN-1:0] a,
    input  logic [rv_core_pkg::XLEN-1:0] b,
    output logic [rv_core_pkg::XLEN-1:0] result,
    output logic                          taken
);

    logic [rv_core_pkg::XLEN-1:0] diff;
    logic                          eq;
    logic                          lt;

    assign diff = a - b;
    assign eq = (a == b);
    assign lt = $signed(a) < $signed(b);

    always_comb begin
        case (alu_op)
            rv_core_pkg::ALU_ADD: result = a + b;
            rv_core_pkg::ALU_SUB: result = diff;
            rv_core_pkg::ALU_AND: result = a & b;
            rv_core_pkg::ALU_OR: result = a | b;
            rv_core_pkg::ALU_XOR: result = a ^ b;
            rv_core_pkg::ALU_SLT: result = {{(rv_core_pkg::XLEN-1){1'b0}}, lt};
            rv_core_pkg::ALU_EQ: result = {{(rv_core_pkg::XLEN-1){1'b0}}, eq};
            rv_core_pkg::ALU_NE: result = {{(rv_core_pkg::XLEN-1){1'b0}}, !eq};
            default: result = '0;
        endcase
    end

    // Branch decision
    always_comb begin
        case (alu_op)
            rv_core_pkg::ALU_EQ: taken = eq;
            rv_core_pkg::ALU_NE: taken = !eq;
            default: taken = 1'b0;
        endcase
    end

endmodule

//--- source/rv_muldiv.sv
`timescale 1ns/1ps

module rv_muldiv (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  rv_core_pkg::muldiv_op_e       op,
    input  logic [rv_core_pkg::XLEN-1:0] a,
    input  logic [rv_core_pkg::XLEN-1:0] b,
    output logic                          busy,
    output logic                          result_done,
    output logic [rv_core_pkg::XLEN-1:0] result
);

    localparam int W = rv_core_pkg::XLEN;

    logic [rv_core_pkg::MULDIV_CNT_W-1:0] cnt;
    rv_core_pkg::muldiv_op_e               op_q;
    // hi holds product or remainder, lo holds multiplier or quotient
    logic [W-1:0] hi;
    logic [W-1:0] lo;
    logic [W-1:0] b_q;
    logic [W:0]   rem_shift;
    logic         rem_ge;

    assign rem_shift = {hi, lo[W-1]};
    assign rem_ge = rem_shift >= {1'b0, b_q};

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy <= 1'b0;
            result_done <= 1'b0;
            cnt <= '0;
        end else begin
            result_done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == rv_core_pkg::MULDIV_CNT_W'(rv_core_pkg::MULDIV_STEPS - 1)) begin
                    busy <= 1'b0;
                    result_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            op_q <= op;
            hi <= '0;
            lo <= a;
            b_q <= b;
        end else if (busy) begin
            if (op_q == rv_core_pkg::MD_MUL) begin
                if (lo[0]) begin
                    hi <= hi + b_q;
                end
                lo <= lo >> 1;
                b_q <= b_q << 1;
            end else begin
                // Restoring step, divisor of zero yields all ones
                hi <= rem_ge ? rem_shift[W-1:0] - b_q : rem_shift[W-1:0];
                lo <= {lo[W-2:0], rem_ge};
            end
        end
    end

    assign result = (op_q == rv_core_pkg::MD_DIVU) ? lo : hi;

    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst)
        start |-> !busy);

    a_done_latency: assert property (@(posedge clk) disable iff (!rst)
        start |-> ##(rv_core_pkg::MULDIV_STEPS + 1) result_done);

endmodule

//--- source/rv_core_ctrl.sv
`timescale 1ns/1ps

module rv_core_ctrl (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [rv_core_pkg::ILEN-1:0]       instr,
    input  logic                                instr_valid,
    input  logic                                instr_error,
    input  logic [rv_core_pkg::XLEN-1:0]       data_Rd,
    input  logic                                data_Rd_valid,
    input  logic                                data_Rd_error,
    output logic [rv_core_pkg::XLEN-1:0]       pc_rd,
    output logic                                MemRd,
    output logic                                MemWr,
    output logic [2:0]                          MemOp,
    output logic [rv_core_pkg::XLEN-1:0]       addr,
    output logic [rv_core_pkg::XLEN-1:0]       data_Wr,
    output logic [rv_core_pkg::XLEN-1:0]       pc_nxt,
    output logic                                out_valid,
    output logic                                done,
    output logic                                error,
    input  rv_core_pkg::instr_class_e           instr_class,
    input  logic                                use_imm,
    input  logic                                reg_write,
    input  logic [rv_core_pkg::XLEN-1:0]       imm,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] rd,
    output logic [rv_core_pkg::ILEN-1:0]       ir,
    input  logic [rv_core_pkg::XLEN-1:0]       rs1_data,
    input  logic [rv_core_pkg::XLEN-1:0]       rs2_data,
    output logic [rv_core_pkg::XLEN-1:0]       alu_a,
    output logic [rv_core_pkg::XLEN-1:0]       alu_b,
    input  logic [rv_core_pkg::XLEN-1:0]       alu_result,
    input  logic                                alu_taken,
    output logic                                muldiv_start,
    output logic [rv_core_pkg::XLEN-1:0]       muldiv_a,
    output logic [rv_core_pkg::XLEN-1:0]       muldiv_b,
    input  logic                                muldiv_busy,
    input  logic                                muldiv_done,
    input  logic [rv_core_pkg::XLEN-1:0]       muldiv_result,
    output logic                                reg_wen,
    output logic [rv_core_pkg::XLEN-1:0]       reg_wdata,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] reg_rd
);

    rv_core_pkg::ctrl_state_e state;
    logic [rv_core_pkg::XLEN-1:0] pc;
    logic [rv_core_pkg::XLEN-1:0] pc_plus4;
    logic [rv_core_pkg::XLEN-1:0] npc;
    logic                          wb_cond;

    assign pc_rd = pc;
    assign pc_plus4 = pc + 64'd4;

    always_comb begin
        if (instr_class == rv_core_pkg::CLS_JAL ||
            (instr_class == rv_core_pkg::CLS_BRANCH && alu_taken)) begin
            npc = pc + imm;
        end else if (instr_class == rv_core_pkg::CLS_ECALL) begin
            npc = pc;
        end else begin
            npc = pc_plus4;
        end
    end

    assign alu_a = rs1_data;
    assign alu_b = use_imm ? imm : rs2_data;
    assign muldiv_a = rs1_data;
    assign muldiv_b = rs2_data;
    assign muldiv_start = (state == rv_core_pkg::ST_EXEC) &&
                          (instr_class == rv_core_pkg::CLS_MULDIV) && !muldiv_busy;

    // Data memory strobes
    assign MemWr = (state == rv_core_pkg::ST_EXEC) && (instr_class == rv_core_pkg::CLS_STORE);
    assign MemRd = (state == rv_core_pkg::ST_MEM);
    assign MemOp = (MemRd || MemWr) ? rv_core_pkg::MEMOP_D : 3'd0;
    assign addr = alu_result;
    assign data_Wr = rs2_data;

    always_comb begin
        case (state)
            rv_core_pkg::ST_EXEC: wb_cond = (instr_class == rv_core_pkg::CLS_ALU) ||
                                            (instr_class == rv_core_pkg::CLS_JAL);
            rv_core_pkg::ST_MEM: wb_cond = data_Rd_valid && !data_Rd_error;
            rv_core_pkg::ST_MULDIV: wb_cond = muldiv_done;
            default: wb_cond = 1'b0;
        endcase
        case (instr_class)
            rv_core_pkg::CLS_LOAD: reg_wdata = data_Rd;
            rv_core_pkg::CLS_JAL: reg_wdata = pc_plus4;
            rv_core_pkg::CLS_MULDIV: reg_wdata = muldiv_result;
            default: reg_wdata = alu_result;
        endcase
    end

    assign reg_wen = wb_cond && reg_write;
    assign reg_rd = rd;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= rv_core_pkg::ST_FETCH;
            pc <= '0;
            out_valid <= 1'b0;
            done <= 1'b0;
            error <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            case (state)
                rv_core_pkg::ST_FETCH: begin
                    if (instr_valid) begin
                        if (instr_error) begin
                            error <= 1'b1;
                            state <= rv_core_pkg::ST_HALT;
                        end else begin
                            state <= rv_core_pkg::ST_EXEC;
                        end
                    end
                end
                rv_core_pkg::ST_EXEC: begin
                    case (instr_class)
                        rv_core_pkg::CLS_ILLEGAL: begin
                            error <= 1'b1;
                            state <= rv_core_pkg::ST_HALT;
                        end
                        rv_core_pkg::CLS_LOAD: state <= rv_core_pkg::ST_MEM;
                        rv_core_pkg::CLS_MULDIV: state <= rv_core_pkg::ST_MULDIV;
                        default: begin
                            out_valid <= 1'b1;
                            done <= (instr_class == rv_core_pkg::CLS_ECALL);
                            state <= rv_core_pkg::ST_RETIRE;
                        end
                    endcase
                end
                rv_core_pkg::ST_MEM: begin
                    if (data_Rd_valid) begin
                        if (data_Rd_error) begin
                            error <= 1'b1;
                            state <= rv_core_pkg::ST_HALT;
                        end else begin
                            out_valid <= 1'b1;
                            state <= rv_core_pkg::ST_RETIRE;
                        end
                    end
                end
                rv_core_pkg::ST_MULDIV: begin
                    if (muldiv_done) begin
                        out_valid <= 1'b1;
                        state <= rv_core_pkg::ST_RETIRE;
                    end
                end
                rv_core_pkg::ST_RETIRE: begin
                    pc <= pc_nxt;
                    state <= done ? rv_core_pkg::ST_HALT : rv_core_pkg::ST_FETCH;
                end
                default: state <= rv_core_pkg::ST_HALT;
            endcase
        end
    end

    // Instruction word and next pc
    always_ff @(posedge clk) begin
        if (state == rv_core_pkg::ST_FETCH && instr_valid) begin
            ir <= instr;
        end
        if (state == rv_core_pkg::ST_EXEC) begin
            pc_nxt <= npc;
        end
    end

    a_strobe_excl: assert property (@(posedge clk) disable iff (!rst)
        !(MemRd && MemWr));

    a_strobe_after_reset: assert property (@(posedge clk)
        $past(!rst) |-> !MemRd && !MemWr);

endmodule

//--- source/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] instr,
    input  logic        instr_valid,
    input  logic        instr_error,
    input  logic [63:0] data_Rd,
    input  logic        data_Rd_valid,
    input  logic        data_Rd_error,
    output logic [63:0] pc_rd,
    output logic        MemRd,
    output logic        MemWr,
    output logic [2:0]  MemOp,
    output logic [63:0] addr,
    output logic [63:0] data_Wr,
    output logic [63:0] pc_nxt,
    output logic        out_valid,
    output logic        done,
    output logic        error
);

    logic [rv_core_pkg::ILEN-1:0]       ir;
    rv_core_pkg::instr_class_e           instr_class;
    rv_core_pkg::alu_op_e                alu_op;
    rv_core_pkg::muldiv_op_e             muldiv_op;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rs1, rs2, rd, reg_rd;
    logic [rv_core_pkg::XLEN-1:0]       imm, rs1_data, rs2_data, reg_wdata;
    logic                                use_imm, reg_write, reg_wen;
    logic [rv_core_pkg::XLEN-1:0]       alu_a, alu_b, alu_result;
    logic                                alu_taken;
    logic                                muldiv_start, muldiv_busy, muldiv_done;
    logic [rv_core_pkg::XLEN-1:0]       muldiv_a, muldiv_b, muldiv_result;

    rv_core_ctrl u_ctrl (
        .clk(clk), .rst(rst),
        .instr(instr), .instr_valid(instr_valid), .instr_error(instr_error),
        .data_Rd(data_Rd), .data_Rd_valid(data_Rd_valid), .data_Rd_error(data_Rd_error),
        .pc_rd(pc_rd), .MemRd(MemRd), .MemWr(MemWr), .MemOp(MemOp),
        .addr(addr), .data_Wr(data_Wr),
        .pc_nxt(pc_nxt), .out_valid(out_valid), .done(done), .error(error),
        .instr_class(instr_class), .use_imm(use_imm), .reg_write(reg_write),
        .imm(imm), .rd(rd), .ir(ir),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .alu_a(alu_a), .alu_b(alu_b), .alu_result(alu_result), .alu_taken(alu_taken),
        .muldiv_start(muldiv_start), .muldiv_a(muldiv_a), .muldiv_b(muldiv_b),
        .muldiv_busy(muldiv_busy), .muldiv_done(muldiv_done),
        .muldiv_result(muldiv_result),
        .reg_wen(reg_wen), .reg_wdata(reg_wdata), .reg_rd(reg_rd)
    );

    rv_decode u_decode (
        .instr(ir), .instr_class(instr_class), .alu_op(alu_op), .muldiv_op(muldiv_op),
        .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
        .use_imm(use_imm), .reg_write(reg_write)
    );

    rv_regfile u_regfile (
        .clk(clk), .rst(rst),
        .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wen(reg_wen), .rd(reg_rd), .wdata(reg_wdata)
    );

    rv_alu u_alu (
        .alu_op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result), .taken(alu_taken)
    );

    rv_muldiv u_muldiv (
        .clk(clk), .rst(rst), .start(muldiv_start), .op(muldiv_op),
        .a(muldiv_a), .b(muldiv_b),
        .busy(muldiv_busy), .result_done(muldiv_done), .result(muldiv_result)
    );

endmodule

//--- verification/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    logic        instr_valid;
    logic        instr_error;
    logic [63:0] data_Rd;
    logic        data_Rd_valid;
    logic        data_Rd_error;
    logic [63:0] pc_rd;
    logic        MemRd;
    logic        MemWr;
    logic [2:0]  MemOp;
    logic [63:0] addr;
    logic [63:0] data_Wr;
    logic [63:0] pc_nxt;
    logic        out_valid;
    logic        done;
    logic        error;

    logic [63:0]                    vec [0:255];
    logic [rv_core_pkg::ILEN-1:0]   imem [0:63];
    logic [rv_core_pkg::XLEN-1:0]   dmem [0:63];
    int n_prog;
    int n_store;
    int n_trace;
    int done_idx;
    int errors = 0;
    logic loaded = 1'b0;

    rv_core u_dut (
        .clk(clk), .rst(rst),
        .instr(instr), .instr_valid(instr_valid), .instr_error(instr_error),
        .data_Rd(data_Rd), .data_Rd_valid(data_Rd_valid), .data_Rd_error(data_Rd_error),
        .pc_rd(pc_rd), .MemRd(MemRd), .MemWr(MemWr), .MemOp(MemOp),
        .addr(addr), .data_Wr(data_Wr),
        .pc_nxt(pc_nxt), .out_valid(out_valid), .done(done), .error(error)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_xlen(input string name, input logic [rv_core_pkg::XLEN-1:0] exp,
                              input logic [rv_core_pkg::XLEN-1:0] act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_op(input string name, input logic [2:0] exp, input logic [2:0] act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    // Only loads and multiply or divide change the retire latency
    function automatic rv_core_pkg::instr_class_e classify(input logic [31:0] w);
        if (w[6:0] == 7'b0000011) begin
            return rv_core_pkg::CLS_LOAD;
        end
        if (w[6:0] == 7'b0110011 && w[31:25] == 7'b0000001) begin
            return rv_core_pkg::CLS_MULDIV;
        end
        return rv_core_pkg::CLS_ALU;
    endfunction

    task automatic load_vectors();
        $readmemh("verification/rv_core_vectors.txt", vec);
        n_prog = int'(vec[8'h00]);
        for (int i = 0; i < 64; i++) begin
            imem[i] = {i[24:0], 7'h7f};
            dmem[i] = 64'hd00d_0000_0000_0000 | 64'(i * 8);
        end
        for (int i = 0; i < n_prog; i++) begin
            imem[i] = vec[1 + i][31:0];
        end
        for (int i = 0; i < int'(vec[8'h30]); i++) begin
            dmem[vec[8'h31 + 2 * i][8:3]] = vec[8'h32 + 2 * i];
        end
        n_store = int'(vec[8'h40]);
        n_trace = int'(vec[8'h60]);
        done_idx = int'(vec[8'h61]);
        loaded = 1'b1;
    endtask

    task automatic run_program();
        logic fetch_pend;
        logic rd_armed;
        logic halted;
        logic nxt_iv;
        logic nxt_dv;
        logic [63:0] nxt_data;
        int fetch_stall;
        int rd_stall;
        int cycle;
        int accept_cycle;
        int ret_idx;
        int st_idx;
        int quiet;
        rv_core_pkg::instr_class_e cur_class;
        fetch_pend = 1'b1;
        fetch_stall = $urandom % 6;
        rd_armed = 1'b0;
        rd_stall = 0;
        halted = 1'b0;
        cycle = 0;
        accept_cycle = 0;
        ret_idx = 0;
        st_idx = 0;
        quiet = 0;
        cur_class = rv_core_pkg::CLS_ALU;
        while (quiet < 20) begin
            @(negedge clk);
            cycle++;
            nxt_iv = 1'b0;
            nxt_dv = 1'b0;
            nxt_data = data_Rd;
            if (error) begin
                $display("Core raised error while running the program at %0t", $time);
                errors++;
                break;
            end
            if (MemRd && MemWr) begin
                $display("MemRd and MemWr are high together at %0t", $time);
                errors++;
            end
            if (halted) begin
                if (out_valid || MemRd || MemWr) begin
                    $display("Core is still active after ECALL at %0t", $time);
                    errors++;
                end
                // Keep offering fetches, a core that did not halt would take them
                nxt_iv = 1'b1;
                quiet++;
            end else begin
                if (out_valid) begin
                    if (ret_idx >= n_trace) begin
                        $display("More instructions retired than the trace lists");
                        errors++;
                    end else begin
                        check_xlen("pc_nxt", vec[8'h62 + ret_idx], pc_nxt);
                        check_flag("done", ret_idx == done_idx, done);
                    end
                    if (cur_class != rv_core_pkg::CLS_LOAD) begin
                        check_latency("retire_latency",
                                      (cur_class == rv_core_pkg::CLS_MULDIV) ?
                                      rv_core_pkg::MULDIV_STEPS + 3 : 2,
                                      cycle - accept_cycle);
                    end
                    ret_idx++;
                    if (done) begin
                        halted = 1'b1;
                    end else begin
                        fetch_pend = 1'b1;
                        fetch_stall = $urandom % 6;
                    end
                end
                // A valid seen here is taken at the coming edge
                if (instr_valid) begin
                    accept_cycle = cycle;
                    cur_class = classify(instr);
                end else if (fetch_pend) begin
                    if (fetch_stall == 0) begin
                        nxt_iv = 1'b1;
                        fetch_pend = 1'b0;
                    end else begin
                        fetch_stall--;
                    end
                end
                if (MemWr) begin
                    if (st_idx >= n_store) begin
                        $display("Unexpected store to %h at %0t", addr, $time);
                        errors++;
                    end else begin
                        check_xlen("addr", vec[8'h41 + 2 * st_idx], addr);
                        check_xlen("data_Wr", vec[8'h42 + 2 * st_idx], data_Wr);
                    end
                    check_op("MemOp", rv_core_pkg::MEMOP_D, MemOp);
                    dmem[addr[8:3]] = data_Wr;
                    st_idx++;
                end
                if (MemRd && !data_Rd_valid) begin
                    if (!rd_armed) begin
                        rd_armed = 1'b1;
                        rd_stall = $urandom % 6;
                    end
                    if (rd_stall == 0) begin
                        check_op("MemOp", rv_core_pkg::MEMOP_D, MemOp);
                        nxt_dv = 1'b1;
                        nxt_data = dmem[addr[8:3]];
                        rd_armed = 1'b0;
                    end else begin
                        rd_stall--;
                    end
                end
            end
            @(posedge clk);
            #1;
            instr_valid = nxt_iv;
            if (nxt_iv) begin
                instr = imem[pc_rd[7:2]];
            end
            data_Rd_valid = nxt_dv;
            data_Rd = nxt_data;
        end
        if (ret_idx != n_trace) begin
            $display("Retired %0d instructions but the trace lists %0d", ret_idx, n_trace);
            errors++;
        end
        if (st_idx != n_store) begin
            $display("Saw %0d stores but %0d were expected", st_idx, n_store);
            errors++;
        end
    endtask

    // Fetch error right after reset
    task automatic error_segment();
        int waited;
        @(posedge clk);
        #1;
        rst = 1'b0;
        instr_valid = 1'b0;
        data_Rd_valid = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b1;
        instr = imem[0];
        instr_valid = 1'b1;
        instr_error = 1'b1;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        instr_error = 1'b0;
        waited = 0;
        while (waited < 10) begin
            @(negedge clk);
            check_flag("out_valid", 1'b0, out_valid);
            if (error) begin
                break;
            end
            waited++;
        end
        if (waited == 10) begin
            $display("Core did not raise error after a failed fetch");
            errors++;
        end
        check_flag("error", 1'b1, error);
        check_flag("done", 1'b0, done);
    endtask

    initial begin
        rst = 1'b0;
        instr = '0;
        instr_valid = 1'b0;
        instr_error = 1'b0;
        data_Rd = '0;
        data_Rd_valid = 1'b0;
        data_Rd_error = 1'b0;
        void'($urandom(32'h5611a16e));
        load_vectors();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b1;
        run_program();
        error_segment();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (n_prog * (rv_core_pkg::MULDIV_STEPS + 20)) @(posedge clk);
        $display("Watchdog expired before the run finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- verification/rv_core_vectors.txt
// Sections: @00 program count then words, @30 data count then (addr data) pairs,
// @40 store count then (addr data) pairs, @60 retire count, done index, pc_nxt list
@00
24
10000093 0000B103 0080B183 00310233 402182B3 00317333 003163B3 00314433
0002A4B3 02310533 023155B3 02317633 020156B3 02017733 00000463 00000213
00211463 00311463 00000293 008007EF 00000313 0040B823 0050BC23 0260B023
0270B423 0280B823 0290BC23 04A0B023 04B0B423 04C0B823 04D0BC23 06E0B023
06F0B423 0100B803 0700B823 00000073
@30
2
100 3E8
108 2D
@40
D
110 415
118 FFFFFFFFFFFFFC45
120 28
128 3ED
130 3C5
138 1
140 AFC8
148 16
150 A
158 FFFFFFFFFFFFFFFF
160 3E8
168 50
170 415
@60
21 20
04 08 0C 10 14 18 1C 20 24 28 2C 30 34 38 40 44
4C 54 58 5C 60 64 68 6C 70 74 78 7C 80 84 88 8C 8C

//--- project.f
source/rv_core_pkg.sv
source/rv_regfile.sv
source/rv_decode.sv
source/rv_alu.sv
source/rv_muldiv.sv
source/rv_core_ctrl.sv
source/rv_core.sv
verification/rv_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module rv_core_tb -f project.f -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rv_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
    exit 1
fi
exit 0
